// ==== rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// ====================
// Rename resource sizes
// ====================

// Number of physical registers in the rename pool
// Each one owns a row of valid bits in the valid RAM
`define PREGS 32

// Number of rename checkpoints kept by the core
// Each checkpoint owns one column of valid bits
`define NCHECK 4

// ====================
// Bus sizes
// ====================

// APB address width, enough for the command and status registers
`define APB_AW 4

`endif

// ==== rename_pkg.sv ====
`include "rename_cfg.svh"

// Types that describe the rename resources themselves
// The sizes come from the configuration header so the whole design scales together
package rename_pkg;

	// ====================
	// Index types
	// ====================

	// Physical register number, one per row of the valid array
	typedef logic [$clog2(`PREGS)-1:0] pregno_t;

	// Checkpoint index, selects one column of the valid array
	typedef logic [$clog2(`NCHECK)-1:0] checkpt_ndx_t;

	// ====================
	// Mask types
	// ====================

	// One bit per checkpoint
	// Used both for the in-use mask and for a full row of valid bits
	typedef logic [`NCHECK-1:0] ckpt_mask_t;

endpackage

// ==== apb_regs_pkg.sv ====
`include "rename_cfg.svh"

// Software view of the tracker: register offsets, command opcodes and field positions
package apb_regs_pkg;

	// ====================
	// Register map
	// ====================

	// Command register, a write starts one command
	localparam logic [`APB_AW-1:0] REG_CMD = 'h0;
	// Status register, read only
	localparam logic [`APB_AW-1:0] REG_STATUS = 'h4;

	// Command opcodes carried in the low bits of a REG_CMD write
	// Codes 6 and 7 are unused and get refused
	typedef enum logic [2:0] {
		OP_SET_VALID = 3'd0,
		OP_CLR_VALID = 3'd1,
		OP_SET_ALL = 3'd2,
		OP_READ = 3'd3,
		OP_ALLOC = 3'd4,
		OP_FREE = 3'd5
	} valid_op_e;

	// ====================
	// Field positions
	// ====================

	// Command word layout
	localparam int CMD_OP_LSB = 0;
	localparam int CMD_OP_MSB = 2;
	localparam int CMD_CK_LSB = 4;
	localparam int CMD_CK_MSB = 5;
	localparam int CMD_RG_LSB = 8;
	localparam int CMD_RG_MSB = 12;

	// Status word layout
	localparam int STS_RESULT_BIT = 0;
	localparam int STS_AFAIL_BIT = 1;
	localparam int STS_LAST_LSB = 4;
	localparam int STS_LAST_MSB = 5;
	// In-use mask is one bit per checkpoint
	localparam int STS_INUSE_LSB = 8;
	localparam int STS_INUSE_MSB = STS_INUSE_LSB + `NCHECK - 1;

endpackage

// ==== valid_port_if.sv ====
`timescale 1ns/1ps

// Write and read lanes into the checkpoint valid RAM
// The controller drives the requests and the RAM returns the read bit
interface valid_port_if import rename_pkg::*; ();

	// Write lane
	logic wr;
	// Row being written
	pregno_t wa;
	// Column being written, ignored when setall is high
	checkpt_ndx_t wc;
	// Set every checkpoint bit of row wa
	logic setall;
	// Bit value for a single-bit write
	logic i;

	// Read lane, the result shows up in o after one clock edge
	logic rd;
	pregno_t ra;
	checkpt_ndx_t rc;
	logic o;

	// Controller side
	modport ctrl (
		output wr, wa, wc, setall, i,
		output rd, ra, rc,
		input o
	);

	// RAM side
	modport ram (
		input wr, wa, wc, setall, i,
		input rd, ra, rc,
		output o
	);

endinterface

// ==== ckpt_valid_ram.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

// Valid bit storage for the physical registers
// There is one row per physical register and one column per checkpoint
// A set bit means the register holds a valid value as seen from that checkpoint
module ckpt_valid_ram import rename_pkg::*; (
	input logic clka,
	input logic rst_n,
	valid_port_if.ram vp
);

	// ====================
	// Storage
	// ====================

	// Indexed by physical register, each entry is a full checkpoint row
	ckpt_mask_t mem [0:`PREGS-1];

	// Write lane
	// Out of reset every register is valid in every checkpoint
	// A core comes up with its architectural registers all mapped and ready
	always_ff @(posedge clka) begin
		if (!rst_n) begin
			for (int r = 0; r < `PREGS; r++) begin
				mem[r] <= {`NCHECK{1'b1}};
			end
		end
		else if (vp.wr) begin
			// Set-all marks the register ready in every checkpoint at once
			// This is what happens when a result is written back
			if (vp.setall) begin
				mem[vp.wa] <= {`NCHECK{1'b1}};
			end
			// Otherwise only the addressed checkpoint bit changes
			else begin
				mem[vp.wa][vp.wc] <= vp.i;
			end
		end
	end

	// ====================
	// Read lane
	// ====================

	// Registered read of one bit
	// A write in the same cycle is not visible here, the old bit is returned
	// The controller never issues both in one cycle, so this does not arise
	always_ff @(posedge clka) begin
		if (vp.rd) begin
			vp.o <= mem[vp.ra][vp.rc];
		end
	end

endmodule

// ==== ckpt_alloc.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

// Checkpoint allocator
// Keeps a mask of checkpoints in use and hands out the lowest free one
module ckpt_alloc import rename_pkg::*; (
	input logic clka,
	input logic rst_n,
	input logic alloc_req,
	input logic free_req,
	input checkpt_ndx_t free_ndx,
	output checkpt_ndx_t alloc_ndx,
	output logic alloc_ok,
	output ckpt_mask_t in_use
);

	// ====================
	// Free search
	// ====================

	// Scan from the top down so the lowest clear bit is the last one to win
	// Both outputs depend only on the mask, so they are stable for the whole
	// access cycle and the controller can latch them with the request
	always_comb begin
		alloc_ndx = '0;
		alloc_ok = 1'b0;
		for (int k = `NCHECK - 1; k >= 0; k--) begin
			if (!in_use[k]) begin
				alloc_ndx = checkpt_ndx_t'(k);
				alloc_ok = 1'b1;
			end
		end
	end

	// ====================
	// In-use mask
	// ====================

	// Checkpoint 0 is live out of reset, it holds the committed state
	// Any checkpoint, 0 included, can be freed later so all of them recycle
	always_ff @(posedge clka) begin
		if (!rst_n) begin
			in_use <= ckpt_mask_t'(1);
		end
		else begin
			// A full mask makes the request a no-op
			// The controller reports that case through its own flag
			if (alloc_req && alloc_ok) begin
				in_use[alloc_ndx] <= 1'b1;
			end
			// Release the named checkpoint
			// The controller never asks for both in one cycle
			if (free_req) begin
				in_use[free_ndx] <= 1'b0;
			end
		end
	end

endmodule

// ==== valid_apb_ctrl.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

// APB slave in front of the valid RAM and the checkpoint allocator
// A write to REG_CMD runs one command, REG_STATUS returns the results
// The slave has no wait states, pready follows the access cycle directly
module valid_apb_ctrl import rename_pkg::*, apb_regs_pkg::*; (
	input logic clka,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_AW-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	valid_port_if.ctrl vp,
	output logic alloc_req,
	output logic free_req,
	output checkpt_ndx_t free_ndx,
	input checkpt_ndx_t alloc_ndx,
	input logic alloc_ok,
	input ckpt_mask_t in_use
);

	logic access;
	logic cmd_sel;
	logic sts_sel;
	logic op_known;
	logic ck_live;
	logic cmd_ok;
	logic cmd_go;
	logic rd_pend;
	logic result_q;
	logic afail_q;
	checkpt_ndx_t last_q;
	checkpt_ndx_t ck;
	pregno_t rg;
	valid_op_e op;
	logic [31:0] status_word;

	// ====================
	// Command decode
	// ====================

	// Second phase of an APB transfer
	assign access = psel & penable;
	assign cmd_sel = (paddr == REG_CMD);
	assign sts_sel = (paddr == REG_STATUS);

	// Split the write data into command fields
	assign op = valid_op_e'(pwdata[CMD_OP_MSB:CMD_OP_LSB]);
	assign ck = pwdata[CMD_CK_MSB:CMD_CK_LSB];
	assign rg = pwdata[CMD_RG_MSB:CMD_RG_LSB];

	// The named checkpoint has to be live, except for an allocation
	assign ck_live = in_use[ck];

	// Codes outside the enum have no meaning and are refused
	always_comb begin
		case (op)
			OP_SET_VALID, OP_CLR_VALID, OP_SET_ALL,
			OP_READ, OP_ALLOC, OP_FREE: op_known = 1'b1;
			default: op_known = 1'b0;
		endcase
	end

	// A command is accepted only when everything about it checks out
	// A refused command changes no state at all
	assign cmd_ok = cmd_sel & op_known & (ck_live | (op == OP_ALLOC));
	assign cmd_go = access & pwrite & cmd_ok;

	// ====================
	// Request fan-out
	// ====================

	// Exactly one request pulses for an accepted command
	// It acts on the edge that closes the access cycle
	always_comb begin
		vp.wr = 1'b0;
		vp.rd = 1'b0;
		alloc_req = 1'b0;
		free_req = 1'b0;
		if (cmd_go) begin
			case (op)
				OP_SET_VALID, OP_CLR_VALID, OP_SET_ALL: vp.wr = 1'b1;
				OP_READ: vp.rd = 1'b1;
				OP_ALLOC: alloc_req = 1'b1;
				OP_FREE: free_req = 1'b1;
				default: ;
			endcase
		end
	end

	// Lane fields come straight from the command word
	// They only matter while the matching request is high
	assign vp.wa = rg;
	assign vp.wc = ck;
	assign vp.setall = (op == OP_SET_ALL);
	// Set writes a one and clear writes a zero
	assign vp.i = (op == OP_SET_VALID);
	assign vp.ra = rg;
	assign vp.rc = ck;
	assign free_ndx = ck;

	// ====================
	// Status register
	// ====================

	// The RAM returns the read bit one edge after the request
	// rd_pend marks the edge where it is safe to take it
	always_ff @(posedge clka) begin
		if (!rst_n) begin
			rd_pend <= 1'b0;
			result_q <= 1'b0;
			afail_q <= 1'b0;
			last_q <= '0;
		end
		else begin
			rd_pend <= vp.rd;
			if (rd_pend) begin
				result_q <= vp.o;
			end
			// A successful allocation clears an earlier failure
			if (alloc_req) begin
				afail_q <= !alloc_ok;
				if (alloc_ok) begin
					last_q <= alloc_ndx;
				end
			end
		end
	end

	// In-use mask is shown live, the other fields are the latched results
	always_comb begin
		status_word = '0;
		status_word[STS_RESULT_BIT] = result_q;
		status_word[STS_AFAIL_BIT] = afail_q;
		status_word[STS_LAST_MSB:STS_LAST_LSB] = last_q;
		status_word[STS_INUSE_MSB:STS_INUSE_LSB] = in_use;
	end

	// ====================
	// APB response
	// ====================

	// No wait states
	assign pready = access;

	// REG_CMD is write only and REG_STATUS is read only
	// A write is also refused when its command does not check out
	assign pslverr = access & (pwrite ? !cmd_ok : !sts_sel);

	// Read data only during a status read, zero otherwise
	assign prdata = (access & !pwrite & sts_sel) ? status_word : 32'h0;

endmodule

// ==== valid_tracker_top.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

// Valid bit tracker top level
// APB comes in on plain ports, the blocks inside talk through valid_port_if
module valid_tracker_top import rename_pkg::*; (
	input logic clka,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_AW-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	// Allocator handshake
	logic alloc_req;
	logic free_req;
	checkpt_ndx_t free_ndx;
	checkpt_ndx_t alloc_ndx;
	logic alloc_ok;
	ckpt_mask_t in_use;

	// Lanes between controller and RAM
	valid_port_if vp ();

	// ====================
	// Instances
	// ====================

	valid_apb_ctrl u_ctrl (
		.clka(clka),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.vp(vp),
		.alloc_req(alloc_req),
		.free_req(free_req),
		.free_ndx(free_ndx),
		.alloc_ndx(alloc_ndx),
		.alloc_ok(alloc_ok),
		.in_use(in_use)
	);

	ckpt_valid_ram u_ram (
		.clka(clka),
		.rst_n(rst_n),
		.vp(vp)
	);

	ckpt_alloc u_alloc (
		.clka(clka),
		.rst_n(rst_n),
		.alloc_req(alloc_req),
		.free_req(free_req),
		.free_ndx(free_ndx),
		.alloc_ndx(alloc_ndx),
		.alloc_ok(alloc_ok),
		.in_use(in_use)
	);

endmodule

// ==== valid_tracker_properties.sv ====
`timescale 1ns/1ps

// Protocol and lane checks on the tracker, bound into valid_tracker_top
module valid_tracker_properties (
	input logic clka,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic wr,
	input logic rd
);

	// Number of failed assertions, the testbench adds it to its error total
	int fail_count = 0;

	// ====================
	// APB
	// ====================

	// The slave has no wait states
	a_ready_in_access: assert property (
		@(posedge clka) disable iff (!rst_n) (psel && penable) |-> pready
	) else begin
		$error("pready was low during an APB access cycle");
		fail_count++;
	end

	// An error response only belongs to an access cycle
	a_slverr_in_access: assert property (
		@(posedge clka) disable iff (!rst_n) !(psel && penable) |-> !pslverr
	) else begin
		$error("pslverr was high outside an APB access cycle");
		fail_count++;
	end

	// ====================
	// RAM lanes
	// ====================

	// One command at a time means one lane at a time
	a_one_lane: assert property (
		@(posedge clka) disable iff (!rst_n) !(wr && rd)
	) else begin
		$error("RAM write and read lanes were active in the same cycle");
		fail_count++;
	end

endmodule

// Attach to the top level, the lanes come from the internal interface
bind valid_tracker_top valid_tracker_properties u_props (
	.clka(clka),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.wr(vp.wr),
	.rd(vp.rd)
);

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

// Free-running testbench clock
module tb_clkgen (
	output logic clka
);

	// Full period in ns, the clock toggles every half period
	localparam int PERIOD_NS = 100;

	initial clka = 1'b0;

	always #(PERIOD_NS / 2) clka = ~clka;

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

// Watches the APB bus and compares each access cycle against the expected response
// The expected values are driven by the stimulus together with the setup cycle
module tb_checker (
	input logic clka,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic [31:0] prdata,
	input logic pready,
	input logic pslverr,
	input logic [31:0] exp_prdata,
	input logic exp_err
);

	// Stimulus changes on the falling edge
	// Sampling a quarter period later keeps clear of both clock edges
	localparam int SAMPLE_NS = 25;

	int check_count = 0;
	int err_count = 0;
	int test_errs = 0;
	int test_num = 0;

	task automatic count_error();
		err_count++;
		test_errs++;
	endtask

	// ====================
	// Access cycle compare
	// ====================

	always @(negedge clka) begin
		#(SAMPLE_NS);
		if (rst_n && psel && penable) begin
			check_count++;
			if (pready !== 1'b1) begin
				$display("Mismatch pready: got 0x%h, expected 0x1", pready);
				count_error();
			end
			if (prdata !== exp_prdata) begin
				$display("Mismatch prdata: got 0x%08h, expected 0x%08h", prdata, exp_prdata);
				count_error();
			end
			if (pslverr !== exp_err) begin
				$display("Mismatch pslverr: got 0x%h, expected 0x%h", pslverr, exp_err);
				count_error();
			end
		end
		// Outside an access cycle the slave gives no response at all
		else if (rst_n) begin
			if (pready !== 1'b0) begin
				$display("Mismatch pready (idle): got 0x%h, expected 0x0", pready);
				count_error();
			end
			if (pslverr !== 1'b0) begin
				$display("Mismatch pslverr (idle): got 0x%h, expected 0x0", pslverr);
				count_error();
			end
		end
	end

	// One summary line per finished test
	task automatic end_test(input string name);
		test_num++;
		if (test_errs == 0) begin
			$display("Test %0d (%s): ok", test_num, name);
		end
		else begin
			$display("Test %0d (%s): %0d errors", test_num, name, test_errs);
		end
		test_errs = 0;
	endtask

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

// Testbench for the valid bit tracker
// APB stimulus, a shadow model of the expected responses, and the final report
module tb_top import rename_pkg::*, apb_regs_pkg::*; ();

	localparam int CLK_NS = 100;
	localparam int RAND_ITER = 40;
	// Transactions over all five tests, used to size the watchdog
	localparam int TXN_TOTAL = 2 * `PREGS + 9 + 3 * RAND_ITER + 13 + 12;

	logic clka;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [31:0] exp_prdata;
	logic exp_err;

	// Shadow state of the tracker
	ckpt_mask_t sh_valid [0:`PREGS-1];
	ckpt_mask_t sh_inuse;
	logic sh_result;
	logic sh_afail;
	checkpt_ndx_t sh_last;

	int total_errors;
	checkpt_ndx_t rnd_ck;
	pregno_t rnd_rg;

	tb_clkgen u_clk (.clka(clka));

	valid_tracker_top u_dut (
		.clka(clka),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	tb_checker u_chk (
		.clka(clka),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.exp_prdata(exp_prdata),
		.exp_err(exp_err)
	);

	// ====================
	// Reference model
	// ====================

	// Returns the expected prdata of one transfer and sets the expected error
	// An accepted command is applied to the shadow state right away
	function automatic logic [31:0] ref_access(input logic is_wr,
			input logic [`APB_AW-1:0] addr, input logic [31:0] data, output logic err);
		logic [2:0] op;
		checkpt_ndx_t ck;
		pregno_t rg;
		logic [31:0] rdata;
		logic found;
		op = data[2:0];
		ck = data[5:4];
		rg = data[12:8];
		rdata = '0;
		err = 1'b0;
		found = 1'b0;
		if (!is_wr) begin
			if (addr != REG_STATUS) begin
				err = 1'b1;
			end
			else begin
				rdata[0] = sh_result;
				rdata[1] = sh_afail;
				rdata[5:4] = sh_last;
				rdata[11:8] = sh_inuse;
			end
		end
		// Wrong register, or an opcode outside the defined set
		else if (addr != REG_CMD || op > 3'd5) begin
			err = 1'b1;
		end
		// Every command but an allocation needs a live checkpoint
		else if (op != OP_ALLOC && !sh_inuse[ck]) begin
			err = 1'b1;
		end
		else begin
			case (op)
				OP_SET_VALID: sh_valid[rg][ck] = 1'b1;
				OP_CLR_VALID: sh_valid[rg][ck] = 1'b0;
				OP_SET_ALL: sh_valid[rg] = '1;
				OP_READ: sh_result = sh_valid[rg][ck];
				OP_FREE: sh_inuse[ck] = 1'b0;
				OP_ALLOC: begin
					// Lowest free checkpoint wins
					for (int k = 0; k < `NCHECK; k++) begin
						if (!found && !sh_inuse[k]) begin
							found = 1'b1;
							sh_inuse[k] = 1'b1;
							sh_last = checkpt_ndx_t'(k);
						end
					end
					sh_afail = !found;
				end
				default: ;
			endcase
		end
		return rdata;
	endfunction

	// ====================
	// APB stimulus
	// ====================

	// Setup, access and one idle cycle, all driven on falling edges
	task automatic apb_xfer(input logic is_wr, input logic [`APB_AW-1:0] addr,
			input logic [31:0] data);
		logic err;
		@(negedge clka);
		exp_prdata = ref_access(is_wr, addr, data, err);
		exp_err = err;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = is_wr;
		paddr = addr;
		pwdata = is_wr ? data : 32'h0;
		@(negedge clka);
		penable = 1'b1;
		@(negedge clka);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic send_cmd(input logic [2:0] op, input checkpt_ndx_t ck, input pregno_t rg);
		logic [31:0] word;
		word = '0;
		word[2:0] = op;
		word[5:4] = ck;
		word[12:8] = rg;
		apb_xfer(1'b1, REG_CMD, word);
	endtask

	task automatic read_status();
		apb_xfer(1'b0, REG_STATUS, 32'h0);
	endtask

	// Ends the run if the DUT or the stimulus stops making progress
	initial begin
		#(TXN_TOTAL * 4 * CLK_NS + 20 * CLK_NS);
		$display("Timeout: the tests did not finish within the expected run time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exp_prdata = '0;
		exp_err = 1'b0;
		rst_n = 1'b0;
		void'($urandom(32'ha2b8));
		// Reset state of the shadow model
		for (int r = 0; r < `PREGS; r++) begin
			sh_valid[r] = '1;
		end
		sh_inuse = ckpt_mask_t'(1);
		sh_result = 1'b0;
		sh_afail = 1'b0;
		sh_last = '0;
		repeat (10) @(posedge clka);
		@(negedge clka);
		rst_n = 1'b1;

		// Every register starts valid in checkpoint 0
		for (int r = 0; r < `PREGS; r++) begin
			send_cmd(OP_READ, '0, pregno_t'(r));
			read_status();
		end
		u_chk.end_test("reset values");

		// Three allocations fill the free checkpoints, the fourth fails
		read_status();
		repeat (4) begin
			send_cmd(OP_ALLOC, '0, '0);
			read_status();
		end
		u_chk.end_test("checkpoint allocation");

		for (int n = 0; n < RAND_ITER; n++) begin
			rnd_ck = checkpt_ndx_t'($urandom_range(`NCHECK - 1, 0));
			rnd_rg = pregno_t'($urandom_range(`PREGS - 1, 0));
			if ($urandom_range(1, 0) == 1) begin
				send_cmd(OP_SET_VALID, rnd_ck, rnd_rg);
			end
			else begin
				send_cmd(OP_CLR_VALID, rnd_ck, rnd_rg);
			end
			send_cmd(OP_READ, rnd_ck, rnd_rg);
			read_status();
		end
		u_chk.end_test("random set and clear");

		// Clear a whole row, then bring it back with one command
		for (int k = 0; k < `NCHECK; k++) begin
			send_cmd(OP_CLR_VALID, checkpt_ndx_t'(k), 5'd7);
		end
		send_cmd(OP_SET_ALL, '0, 5'd7);
		for (int k = 0; k < `NCHECK; k++) begin
			send_cmd(OP_READ, checkpt_ndx_t'(k), 5'd7);
			read_status();
		end
		u_chk.end_test("set all");

		// A freed checkpoint refuses commands and keeps its bits
		// Row 7 is all ones here, so a clear that slips through reads back as zero
		send_cmd(OP_FREE, 2'd2, '0);
		read_status();
		send_cmd(OP_SET_VALID, 2'd2, 5'd7);
		send_cmd(OP_CLR_VALID, 2'd2, 5'd7);
		send_cmd(OP_READ, 2'd2, 5'd7);
		send_cmd(OP_ALLOC, '0, '0);
		read_status();
		send_cmd(OP_READ, 2'd2, 5'd7);
		read_status();
		// Undefined opcode, unknown address, and a write to the status register
		send_cmd(3'd6, '0, '0);
		apb_xfer(1'b0, 4'h8, 32'h0);
		apb_xfer(1'b1, REG_STATUS, 32'h0);
		u_chk.end_test("free and error cases");

		total_errors = u_chk.err_count + u_dut.u_props.fail_count;
		$display("Tests: %0d, checks: %0d, errors: %0d",
			u_chk.test_num, u_chk.check_count, total_errors);
		if (total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end
		else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
rename_pkg.sv
apb_regs_pkg.sv
valid_port_if.sv
ckpt_valid_ram.sv
ckpt_alloc.sv
valid_apb_ctrl.sv
valid_tracker_top.sv
valid_tracker_properties.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP = tb_top
FILELIST = vlog.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
